//--- logic/mem_defines.svh
/*
 * Width macros for the memory data path.
 * Both packages build their types from these, and any module that
 * sizes a port or a loop from a width includes this header as well.
 */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// --------------------
// core side
// --------------------
`define MEM_ADDR_W      32  // byte address
`define MEM_RDATA_W     64  // up to 8 bytes returned
`define MEM_RLEN_W      4   // read length, 1..8
`define MEM_WLEN_W      3   // write length, 1..4

// --------------------
// bus side
// --------------------
`define MEM_DWORD_W     32  // avalon data width
`define MEM_BE_W        4   // byte enables per dword
`define MEM_MAX_DWORDS  3   // 8 bytes at offset 3 span three dwords
`define MEM_BURST_W     3   // burst dword count and avm_burstcount

`endif

//--- logic/mem_core_pkg.sv
/*
 * Types seen by the core on the request port of the memory block.
 * One request carries either a read of 1..8 bytes or a write of
 * 1..4 bytes, selected by rw. Modules refer to these by scoped name.
 */
`include "mem_defines.svh"

package mem_core_pkg;

// --------------------
// request
// --------------------
// a write only ever uses length 1..4 (MEM_WLEN_W worth of range),
// wdata keeps its bytes in the low lanes, little-endian
typedef struct packed {
    logic                       rw;         // 1 = write
    logic [`MEM_ADDR_W-1:0]     address;    // any byte address
    logic [`MEM_RLEN_W-1:0]     length;     // byte count
    logic [`MEM_DWORD_W-1:0]    wdata;      // byte 0 in [7:0]
} core_req_t;

// --------------------
// response
// --------------------
// byte 0 is the byte at the request address, bytes past length read zero
typedef logic [`MEM_RDATA_W-1:0] core_rdata_t;

endpackage

//--- logic/mem_bus_pkg.sv
/*
 * Types on the bus side of the burst planner.
 * A burst is dword aligned with its own byte enables per dword, and
 * bus_cmd_t bundles the Avalon command outputs of the master.
 */
`include "mem_defines.svh"

package mem_bus_pkg;

// --------------------
// burst request
// --------------------
// writes never exceed two dwords, so wdata has two lanes only
typedef struct packed {
    logic                                           rw;
    logic [`MEM_ADDR_W-3:0]                         dword_address;
    logic [`MEM_BURST_W-1:0]                        dword_count;   // 1..3
    logic [`MEM_MAX_DWORDS-1:0][`MEM_BE_W-1:0]      byteenable;    // [0] is first dword
    logic [1:0][`MEM_DWORD_W-1:0]                   wdata;         // already in lane position
} burst_req_t;

// dword i of the burst sits in bits [32*i +: 32]
typedef logic [`MEM_MAX_DWORDS*`MEM_DWORD_W-1:0] burst_rdata_t;

// --------------------
// avalon command
// --------------------
typedef struct packed {
    logic [`MEM_ADDR_W-3:0]     address;    // word address
    logic [`MEM_BE_W-1:0]       byteenable;
    logic [`MEM_BURST_W-1:0]    burstcount;
    logic [`MEM_DWORD_W-1:0]    writedata;
    logic                       read;
    logic                       write;
} bus_cmd_t;

endpackage

//--- logic/link_stage.sv
/*
 * Registered relay for one do/done link.
 * The request is captured when up_do is seen and offered downstream
 * from a register, and the response comes back the same way with a
 * one-cycle up_done. Instantiate once per link with its payload types.
 */
`timescale 1ns/1ps

module link_stage #(
    parameter type req_t  = logic,
    parameter type resp_t = logic
) (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    up_do,
    input  req_t    up_req,
    output logic    up_done,
    output resp_t   up_resp,

    output logic    dn_do,
    output req_t    dn_req,
    input  logic    dn_done,
    input  resp_t   dn_resp
);

typedef enum logic [1:0] {
    S_IDLE,     // waiting for up_do
    S_BUSY,     // dn_do held
    S_DONE,     // up_done pulse
    S_GAP       // wait for up_do to fall
} state_t;

state_t state;

assign dn_do   = (state == S_BUSY);
assign up_done = (state == S_DONE);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= S_IDLE;
    end else begin
        case (state)
            S_IDLE:  if (up_do) state <= S_BUSY;
            S_BUSY:  if (dn_done) state <= S_DONE;
            S_DONE:  state <= S_GAP;
            S_GAP:   if (!up_do) state <= S_IDLE;   // keeps requests apart
            default: state <= S_IDLE;
        endcase
    end
end

// payload registers
always_ff @(posedge clk) begin
    if (state == S_IDLE && up_do) dn_req <= up_req;
    if (state == S_BUSY && dn_done) up_resp <= dn_resp;
end

endmodule

//--- logic/burst_planner.sv
/*
 * Turns a byte request from the core into a dword aligned burst.
 * Byte enables and lane-shifted write data are computed from the
 * address offset and length; on return the read dwords are shifted
 * down by the offset and bytes past length are cleared.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module burst_planner (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        core_do,
    input  mem_core_pkg::core_req_t     core_req,
    output logic                        core_done,
    output mem_core_pkg::core_rdata_t   core_rdata,

    output logic                        burst_do,
    output mem_bus_pkg::burst_req_t     burst_req,
    input  logic                        burst_done,
    input  mem_bus_pkg::burst_rdata_t   burst_rdata
);

localparam int BE_BITS   = `MEM_MAX_DWORDS * `MEM_BE_W;
localparam int RD_BYTES  = `MEM_RDATA_W / 8;

typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,    // burst_do held
    S_WAIT      // done sent, wait for core_do to fall
} state_t;

state_t state;

logic [1:0]                         offset;
logic [4:0]                         span;       // offset + length
logic [4:0]                         span_up;
logic [BE_BITS-1:0]                 be_mask;
logic [2*`MEM_DWORD_W-1:0]          wr_shift;
mem_bus_pkg::burst_rdata_t          rd_shift;
mem_core_pkg::core_rdata_t          rd_aligned;
mem_bus_pkg::burst_req_t            plan;

// --------------------
// alignment
// --------------------
assign offset  = core_req.address[1:0];
assign span    = {3'b000, offset} + {1'b0, core_req.length};
assign span_up = span + 5'd3;   // round up to whole dwords

always_comb begin
    be_mask = '0;
    for (int b = 0; b < BE_BITS; b++) begin
        if (b >= offset && b < span) be_mask[b] = 1'b1;
    end
end

assign wr_shift = {{`MEM_DWORD_W{1'b0}}, core_req.wdata} << {offset, 3'b000};

always_comb begin
    plan.rw            = core_req.rw;
    plan.dword_address = core_req.address[`MEM_ADDR_W-1:2];
    plan.dword_count   = span_up[4:2];
    plan.byteenable    = be_mask;
    plan.wdata         = wr_shift;
end

// --------------------
// read realignment
// --------------------
assign rd_shift = burst_rdata >> {offset, 3'b000};

always_comb begin
    for (int j = 0; j < RD_BYTES; j++) begin
        rd_aligned[8*j +: 8] = (j < core_req.length) ? rd_shift[8*j +: 8] : 8'h00;
    end
end

// --------------------
// sequencing
// --------------------
assign burst_do = (state == S_ISSUE);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state     <= S_IDLE;
        core_done <= 1'b0;
    end else begin
        core_done <= 1'b0;
        case (state)
            S_IDLE: begin
                if (core_do) state <= S_ISSUE;
            end
            S_ISSUE: begin
                if (burst_done) begin
                    state     <= S_WAIT;
                    core_done <= 1'b1;
                end
            end
            S_WAIT: begin
                if (!core_do) state <= S_IDLE;
            end
            default: state <= S_IDLE;
        endcase
    end
end

// core_req is held by the link stage until core_done
always_ff @(posedge clk) begin
    if (state == S_IDLE && core_do) burst_req <= plan;
    if (state == S_ISSUE && burst_done) core_rdata <= rd_aligned;
end

endmodule

//--- logic/avalon_master.sv
/*
 * Avalon-MM master for the aligned bursts of the planner.
 * A read goes out as one command with burstcount set and the data
 * beats are gathered into dword slots. A write sends one beat per
 * dword, each with its own byte enables. burst_done follows the last beat.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module avalon_master (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        burst_do,
    input  mem_bus_pkg::burst_req_t     burst_req,
    output logic                        burst_done,
    output mem_bus_pkg::burst_rdata_t   burst_rdata,

    output mem_bus_pkg::bus_cmd_t       avm_cmd,
    input  logic                        avm_waitrequest,
    input  logic                        avm_readdatavalid,
    input  logic [`MEM_DWORD_W-1:0]     avm_readdata
);

typedef enum logic [2:0] {
    S_IDLE,
    S_RD_CMD,   // read held until accepted
    S_RD_DATA,  // gathering readdatavalid beats
    S_WR,       // write beats
    S_DONE      // burst_done pulse
} state_t;

state_t state;

logic [`MEM_BURST_W-1:0] beat;
logic [`MEM_BURST_W-1:0] next_beat;
logic [`MEM_BURST_W-1:0] last_beat;

assign next_beat  = beat + 1'b1;
assign last_beat  = burst_req.dword_count - 1'b1;
assign burst_done = (state == S_DONE);

// --------------------
// command side
// --------------------
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        state   <= S_IDLE;
        beat    <= '0;
        avm_cmd <= '0;
    end else begin
        case (state)
            S_IDLE: begin
                if (burst_do) begin
                    beat               <= '0;
                    avm_cmd.address    <= burst_req.dword_address;
                    avm_cmd.burstcount <= burst_req.dword_count;
                    if (burst_req.rw) begin
                        avm_cmd.write      <= 1'b1;
                        avm_cmd.byteenable <= burst_req.byteenable[0];
                        avm_cmd.writedata  <= burst_req.wdata[0];
                        state              <= S_WR;
                    end else begin
                        avm_cmd.read <= 1'b1;
                        // multi-dword read bursts take all byte lanes
                        avm_cmd.byteenable <= (burst_req.dword_count == 'd1) ?
                                              burst_req.byteenable[0] : '1;
                        state <= S_RD_CMD;
                    end
                end
            end
            S_RD_CMD: begin
                if (!avm_waitrequest) begin
                    avm_cmd.read <= 1'b0;
                    state        <= S_RD_DATA;
                end
            end
            S_RD_DATA: begin
                if (avm_readdatavalid) begin
                    beat <= next_beat;
                    if (beat == last_beat) state <= S_DONE;
                end
            end
            S_WR: begin
                if (!avm_waitrequest) begin
                    if (beat == last_beat) begin
                        avm_cmd.write <= 1'b0;
                        state         <= S_DONE;
                    end else begin
                        beat               <= next_beat;
                        avm_cmd.byteenable <= burst_req.byteenable[next_beat];
                        avm_cmd.writedata  <= burst_req.wdata[next_beat[0]];  // two lanes max
                    end
                end
            end
            S_DONE: state <= S_IDLE;
            default: state <= S_IDLE;
        endcase
    end
end

// --------------------
// read data slots
// --------------------
always_ff @(posedge clk) begin
    if (state == S_RD_DATA && avm_readdatavalid) begin
        burst_rdata[beat*`MEM_DWORD_W +: `MEM_DWORD_W] <= avm_readdata;
    end
end

endmodule

//--- logic/memory_top.sv
/*
 * Data side of the memory block.
 * The core request passes a link stage, the burst planner, a second
 * link stage and the Avalon master; read data returns the same way.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module memory_top (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        req_do,
    input  mem_core_pkg::core_req_t     req,
    output logic                        req_done,
    output mem_core_pkg::core_rdata_t   rdata,

    // avalon master
    output logic [`MEM_ADDR_W-1:2]      avm_address,
    output logic [`MEM_DWORD_W-1:0]     avm_writedata,
    output logic [`MEM_BE_W-1:0]        avm_byteenable,
    output logic [`MEM_BURST_W-1:0]     avm_burstcount,
    output logic                        avm_read,
    output logic                        avm_write,
    input  logic                        avm_waitrequest,
    input  logic                        avm_readdatavalid,
    input  logic [`MEM_DWORD_W-1:0]     avm_readdata
);

// --------------------
// core link to planner
// --------------------
logic                           plan_do;
logic                           plan_done;
mem_core_pkg::core_req_t        plan_req;
mem_core_pkg::core_rdata_t      plan_rdata;

link_stage #(
    .req_t  (mem_core_pkg::core_req_t),
    .resp_t (mem_core_pkg::core_rdata_t)
) u_core_link (
    .clk     (clk),
    .rst_n   (rst_n),
    .up_do   (req_do),
    .up_req  (req),
    .up_done (req_done),
    .up_resp (rdata),
    .dn_do   (plan_do),
    .dn_req  (plan_req),
    .dn_done (plan_done),
    .dn_resp (plan_rdata)
);

// --------------------
// planner to bus link
// --------------------
logic                           pl_burst_do;
logic                           pl_burst_done;
mem_bus_pkg::burst_req_t        pl_burst_req;
mem_bus_pkg::burst_rdata_t      pl_burst_rdata;

burst_planner u_planner (
    .clk         (clk),
    .rst_n       (rst_n),
    .core_do     (plan_do),
    .core_req    (plan_req),
    .core_done   (plan_done),
    .core_rdata  (plan_rdata),
    .burst_do    (pl_burst_do),
    .burst_req   (pl_burst_req),
    .burst_done  (pl_burst_done),
    .burst_rdata (pl_burst_rdata)
);

logic                           av_burst_do;
logic                           av_burst_done;
mem_bus_pkg::burst_req_t        av_burst_req;
mem_bus_pkg::burst_rdata_t      av_burst_rdata;

link_stage #(
    .req_t  (mem_bus_pkg::burst_req_t),
    .resp_t (mem_bus_pkg::burst_rdata_t)
) u_bus_link (
    .clk     (clk),
    .rst_n   (rst_n),
    .up_do   (pl_burst_do),
    .up_req  (pl_burst_req),
    .up_done (pl_burst_done),
    .up_resp (pl_burst_rdata),
    .dn_do   (av_burst_do),
    .dn_req  (av_burst_req),
    .dn_done (av_burst_done),
    .dn_resp (av_burst_rdata)
);

// --------------------
// avalon master
// --------------------
mem_bus_pkg::bus_cmd_t          avm_cmd;

avalon_master u_avm (
    .clk               (clk),
    .rst_n             (rst_n),
    .burst_do          (av_burst_do),
    .burst_req         (av_burst_req),
    .burst_done        (av_burst_done),
    .burst_rdata       (av_burst_rdata),
    .avm_cmd           (avm_cmd),
    .avm_waitrequest   (avm_waitrequest),
    .avm_readdatavalid (avm_readdatavalid),
    .avm_readdata      (avm_readdata)
);

assign avm_address    = avm_cmd.address;
assign avm_writedata  = avm_cmd.writedata;
assign avm_byteenable = avm_cmd.byteenable;
assign avm_burstcount = avm_cmd.burstcount;
assign avm_read       = avm_cmd.read;
assign avm_write      = avm_cmd.write;

endmodule

//--- dv/memory_sva.sv
/*
 * Concurrent checks on the do/done links and the Avalon command.
 * Bound into every link_stage and into avalon_master; the bus checks
 * are switched on only for the master instance by BUS_CHECKS.
 * The testbench reads the errors count of each instance.
 */
`timescale 1ns/1ps

module memory_sva #(
    parameter bit BUS_CHECKS = 1'b0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    do_in,
    input  logic                    done,
    input  mem_bus_pkg::bus_cmd_t   cmd,
    input  logic                    waitrequest
);

int errors = 0;     // failed assertions in this instance

// --------------------
// handshake
// --------------------
done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> (!done && !do_in))
    else begin
        errors++;
        $error("done longer than one cycle or do still high after done");
    end

done_with_do: assert property (@(posedge clk) disable iff (!rst_n) done |-> do_in)
    else begin
        errors++;
        $error("done raised while do was low");
    end

// --------------------
// avalon command
// --------------------
generate
    if (BUS_CHECKS) begin : g_bus
        cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
            ((cmd.read || cmd.write) && waitrequest) |=> $stable(cmd))
            else begin
                errors++;
                $error("avalon command changed during waitrequest");
            end

        one_dir: assert property (@(posedge clk) disable iff (!rst_n)
            !(cmd.read && cmd.write))
            else begin
                errors++;
                $error("avm_read and avm_write high together");
            end
    end
endgenerate

endmodule

bind avalon_master memory_sva #(.BUS_CHECKS(1'b1)) u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .do_in       (burst_do),
    .done        (burst_done),
    .cmd         (avm_cmd),
    .waitrequest (avm_waitrequest)
);

bind link_stage memory_sva #(.BUS_CHECKS(1'b0)) u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .do_in       (up_do),
    .done        (up_done),
    .cmd         ('0),
    .waitrequest (1'b0)
);

//--- dv/memory_tb.sv
/*
 * Testbench for the memory data path.
 * Runs a table of core reads and writes through memory_top against a
 * byte-array Avalon memory model. The table runs once with a quiet bus
 * and once with random waitrequest and read latency. Read data is
 * checked against a shadow copy, and each bus command against the
 * alignment rules.
 */
`timescale 1ns/1ps
`include "mem_defines.svh"

module memory_tb;

localparam int N_STIM         = 17;
localparam int RESET_CYCLES   = 8;
localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * N_STIM * 40;   // two passes

typedef struct packed {
    mem_core_pkg::core_req_t    req;
    logic [`MEM_BURST_W-1:0]    dwords;     // expected burstcount / beat count
} stim_t;

logic                           clk;
logic                           rst_n;
logic                           req_do;
mem_core_pkg::core_req_t        req;
logic                           req_done;
mem_core_pkg::core_rdata_t      rdata;
logic [`MEM_ADDR_W-1:2]         avm_address;
logic [`MEM_DWORD_W-1:0]        avm_writedata;
logic [`MEM_BE_W-1:0]           avm_byteenable;
logic [`MEM_BURST_W-1:0]        avm_burstcount;
logic                           avm_read;
logic                           avm_write;
logic                           avm_waitrequest;
logic                           avm_readdatavalid;
logic [`MEM_DWORD_W-1:0]        avm_readdata;

stim_t                          stim [N_STIM];
logic [7:0]                     mem [256];      // bus memory model
logic [7:0]                     shadow [256];   // what the core expects
mem_bus_pkg::bus_cmd_t          exp_beats [$];
logic [31:0]                    rng_state;
logic                           random_bus;
int                             rd_left;
int                             rd_wait;
int                             wr_beat;
logic [29:0]                    rd_addr;
int                             cycle_cnt;

memory_top DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_do            (req_do),
    .req               (req),
    .req_done          (req_done),
    .rdata             (rdata),
    .avm_address       (avm_address),
    .avm_writedata     (avm_writedata),
    .avm_byteenable    (avm_byteenable),
    .avm_burstcount    (avm_burstcount),
    .avm_read          (avm_read),
    .avm_write         (avm_write),
    .avm_waitrequest   (avm_waitrequest),
    .avm_readdatavalid (avm_readdatavalid),
    .avm_readdata      (avm_readdata)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

// --------------------
// helpers
// --------------------
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// bit k of dword dw is set when byte 4*dw+k - offset lies in 0..len-1
function automatic logic [3:0] lane_enables(input logic [31:0] addr, input int len, input int dw);
    logic [3:0] be;
    int pos;
    be = '0;
    for (int k = 0; k < 4; k++) begin
        pos = 4 * dw + k - int'(addr[1:0]);
        if (pos >= 0 && pos < len) be[k] = 1'b1;
    end
    return be;
endfunction

function automatic mem_bus_pkg::bus_cmd_t make_cmd(input logic [31:0] addr,
                                                   input logic [2:0] count,
                                                   input logic [3:0] be,
                                                   input logic rd,
                                                   input logic wr);
    mem_bus_pkg::bus_cmd_t c;
    c = '0;
    c.address    = addr[31:2];
    c.byteenable = be;
    c.burstcount = count;
    c.read       = rd;
    c.write      = wr;
    return c;
endfunction

function automatic int assertion_failures();
    return DUT.u_core_link.u_sva.errors + DUT.u_bus_link.u_sva.errors +
           DUT.u_avm.u_sva.errors;
endfunction

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first failure");
endtask

task automatic check_rdata(input mem_core_pkg::core_rdata_t got,
                           input mem_core_pkg::core_rdata_t exp);
    if (got !== exp) begin
        fail_run($sformatf("error at %0t ns: rdata %h, expected %h", $time, got, exp));
    end
endtask

task automatic check_beat(input mem_bus_pkg::bus_cmd_t got, input mem_bus_pkg::bus_cmd_t exp);
    if (got.address !== exp.address || got.byteenable !== exp.byteenable ||
        got.burstcount !== exp.burstcount || got.read !== exp.read ||
        got.write !== exp.write) begin
        fail_run($sformatf({"error at %0t ns: beat addr %h be %h bc %0d rd %b wr %b,",
                            " expected addr %h be %h bc %0d rd %b wr %b"}, $time,
                           got.address, got.byteenable, got.burstcount, got.read, got.write,
                           exp.address, exp.byteenable, exp.burstcount, exp.read, exp.write));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
endtask

task automatic set_stim(input int i, input logic rw, input logic [31:0] addr,
                        input logic [3:0] len, input logic [31:0] wdata,
                        input logic [2:0] dwords);
    stim[i].req.rw      = rw;
    stim[i].req.address = addr;
    stim[i].req.length  = len;
    stim[i].req.wdata   = wdata;
    stim[i].dwords      = dwords;
endtask

// --------------------
// stimulus table
// --------------------
task automatic load_table();
    //           rw    address   len   wdata         dwords
    set_stim(0,  1'b1, 32'h10,   4'd4, 32'hA1B2C3D4, 3'd1);   // aligned word write
    set_stim(1,  1'b0, 32'h10,   4'd4, 32'h0,        3'd1);
    set_stim(2,  1'b1, 32'h23,   4'd3, 32'h00776655, 3'd2);   // be 0x8 then 0x3
    set_stim(3,  1'b0, 32'h20,   4'd8, 32'h0,        3'd2);
    set_stim(4,  1'b0, 32'h24,   4'd4, 32'h0,        3'd1);
    set_stim(5,  1'b0, 32'h42,   4'd8, 32'h0,        3'd3);   // three dword read
    set_stim(6,  1'b0, 32'h50,   4'd1, 32'h0,        3'd1);
    set_stim(7,  1'b0, 32'h51,   4'd1, 32'h0,        3'd1);
    set_stim(8,  1'b0, 32'h52,   4'd1, 32'h0,        3'd1);
    set_stim(9,  1'b0, 32'h53,   4'd1, 32'h0,        3'd1);
    set_stim(10, 1'b1, 32'h61,   4'd2, 32'h0000BEEF, 3'd1);
    set_stim(11, 1'b0, 32'h60,   4'd4, 32'h0,        3'd1);
    set_stim(12, 1'b1, 32'h72,   4'd4, 32'h12345678, 3'd2);
    set_stim(13, 1'b0, 32'h71,   4'd6, 32'h0,        3'd2);
    set_stim(14, 1'b1, 32'h87,   4'd1, 32'h0000005A, 3'd1);
    set_stim(15, 1'b0, 32'h85,   4'd8, 32'h0,        3'd3);
    set_stim(16, 1'b0, 32'h23,   4'd3, 32'h0,        3'd2);
endtask

task automatic fill_memory();
    for (int i = 0; i < 256; i++) begin
        rng_state = xorshift32(rng_state);
        mem[i]    = rng_state[7:0] ^ i[7:0];
        shadow[i] = mem[i];
    end
endtask

task automatic run_request(input stim_t s);
    mem_core_pkg::core_rdata_t exp_rdata;
    logic [7:0] idx;
    exp_rdata = '0;
    if (s.req.rw) begin
        for (int i = 0; i < int'(s.dwords); i++) begin
            exp_beats.push_back(make_cmd(s.req.address, s.dwords,
                                         lane_enables(s.req.address, int'(s.req.length), i),
                                         1'b0, 1'b1));
        end
        for (int j = 0; j < 4; j++) begin
            idx = s.req.address[7:0] + j[7:0];
            if (j < int'(s.req.length)) shadow[idx] = s.req.wdata[8*j +: 8];
        end
    end else begin
        // a read of more than one dword takes all lanes
        exp_beats.push_back(make_cmd(s.req.address, s.dwords,
                                     (s.dwords == 3'd1) ?
                                     lane_enables(s.req.address, int'(s.req.length), 0) : 4'hf,
                                     1'b1, 1'b0));
        for (int j = 0; j < 8; j++) begin
            idx = s.req.address[7:0] + j[7:0];
            if (j < int'(s.req.length)) exp_rdata[8*j +: 8] = shadow[idx];
        end
    end

    @(posedge clk);
    #2;
    req    = s.req;
    req_do = 1'b1;
    @(negedge clk);
    while (!req_done) @(negedge clk);
    if (!s.req.rw) check_rdata(rdata, exp_rdata);
    if (exp_beats.size() != 0) fail_run("request finished before all of its bus beats were seen");
    @(posedge clk);
    #2;
    req_do = 1'b0;
endtask

// --------------------
// bus memory model
// --------------------
initial begin
    mem_bus_pkg::bus_cmd_t seen;
    logic [7:0] base;
    avm_waitrequest   = 1'b0;
    avm_readdatavalid = 1'b0;
    avm_readdata      = '0;
    rd_left = 0;
    rd_wait = 0;
    wr_beat = 0;
    rd_addr = '0;
    wait (rst_n === 1'b1);
    forever begin
        @(negedge clk);    // values the DUT sees at the coming edge
        seen            = '0;
        seen.address    = avm_address;
        seen.byteenable = avm_byteenable;
        seen.burstcount = avm_burstcount;
        seen.read       = avm_read;
        seen.write      = avm_write;
        if ((avm_read || avm_write) && !avm_waitrequest) begin
            if (exp_beats.size() == 0) fail_run("bus command accepted while none was expected");
            check_beat(seen, exp_beats.pop_front());
            if (avm_write) begin
                base = {avm_address[7:2] + wr_beat[5:0], 2'b00};
                for (int k = 0; k < 4; k++) begin
                    if (avm_byteenable[k]) mem[base + k] = avm_writedata[8*k +: 8];
                end
                wr_beat++;
                if (wr_beat == int'(avm_burstcount)) wr_beat = 0;
            end else begin
                rng_state = xorshift32(rng_state);
                rd_left   = int'(avm_burstcount);
                rd_addr   = avm_address;
                rd_wait   = random_bus ? int'(rng_state[3:2]) : 0;   // 0..3 cycles
            end
        end
        @(posedge clk);
        #2;
        rng_state       = xorshift32(rng_state);
        avm_waitrequest = random_bus && (rng_state[1:0] == 2'b00);
        if (rd_left > 0 && rd_wait == 0) begin
            base              = {rd_addr[5:0], 2'b00};
            avm_readdata      = {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
            avm_readdatavalid = 1'b1;
            rd_addr++;
            rd_left--;
        end else begin
            avm_readdatavalid = 1'b0;
            avm_readdata      = '0;
            if (rd_wait > 0) rd_wait--;
        end
    end
end

always @(negedge clk) begin
    if (assertion_failures() != 0) begin
        fail_run("a bound assertion on the do/done links or the Avalon bus failed");
    end
end

// --------------------
// main sequence
// --------------------
initial begin
    rst_n      = 1'b0;
    req_do     = 1'b0;
    req        = '0;
    random_bus = 1'b0;
    rng_state  = 32'd53339;
    load_table();
    fill_memory();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    @(negedge clk);
    check_flag("req_done", req_done, 1'b0);
    check_flag("avm_read", avm_read, 1'b0);
    check_flag("avm_write", avm_write, 1'b0);

    for (int pass = 0; pass < 2; pass++) begin
        random_bus = (pass == 1);    // second pass stalls the bus
        for (int i = 0; i < N_STIM; i++) run_request(stim[i]);
    end

    repeat (2) @(negedge clk);
    if (exp_beats.size() == 0 && rd_left == 0 && assertion_failures() == 0) begin
        $display("*** TEST PASSED ***");
        $finish;
    end else begin
        fail_run("bus beats, read data or assertion failures were left at the end of the run");
    end
end

initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycle_cnt++;
    end
    fail_run($sformatf("timeout: run did not finish within %0d clock cycles", cycle_cnt));
end

endmodule

//--- tb.f
+incdir+logic
logic/mem_core_pkg.sv
logic/mem_bus_pkg.sv
logic/link_stage.sv
logic/burst_planner.sv
logic/avalon_master.sv
logic/memory_top.sv
dv/memory_sva.sv
dv/memory_tb.sv

//--- Makefile
# Verilator build and run of the memory data path testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/Vmemory_tb: tb.f $(wildcard logic/*.sv logic/*.svh dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module memory_tb -f tb.f

test: obj_dir/Vmemory_tb
	./obj_dir/Vmemory_tb 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
